// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ============================================================
// cache geometry
// ============================================================

`define CACHE_DATA_W         32   // bits per word
`define CACHE_ADDR_W         12   // word address bits

// address split is tag | index | offset
`define CACHE_OFFSET_W        4   // word within a line
`define CACHE_INDEX_W         3   // line select
`define CACHE_TAG_W           5   // remaining upper address bits

// array sizes
`define CACHE_LINES           8   // 2**CACHE_INDEX_W
`define CACHE_WORDS_PER_LINE 16   // 2**CACHE_OFFSET_W

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

  // ============================================================
  // datapath widths
  // ============================================================

  typedef logic [`CACHE_DATA_W-1:0]   word_t;    // one data word
  typedef logic [`CACHE_ADDR_W-1:0]   addr_t;    // word address
  typedef logic [`CACHE_TAG_W-1:0]    tag_t;     // upper address bits
  typedef logic [`CACHE_INDEX_W-1:0]  index_t;   // line number
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t;  // word within line

  // ============================================================
  // controller states
  // ============================================================

  typedef enum logic [1:0] {
    tag_check  = 2'd0,  // serve hits and wait for work
    evict      = 2'd1,  // write back a dirty line
    refill     = 2'd2,  // fetch the missing line
    flush_scan = 2'd3   // look for the next dirty line
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache_dpath_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_dpath_if import cache_pkg::*; ();

  // strobes from the controller
  logic   req_load;     // capture processor request
  logic   tag_write;    // install tag and set valid
  logic   data_write;   // write one word into the data array
  logic   refill_sel;   // refill mode for write data and memory address
  logic   dirty_set;    // store hit marks line dirty
  logic   dirty_clear;  // line is clean again
  logic   victim_sel;   // victim comes from the flush walk
  index_t flush_line;   // line under inspection during flush

  // status back to the controller
  logic   hit;          // request tag matches a valid line
  logic   victim_dirty; // request line holds dirty data
  logic   line_dirty;   // flush_line is valid and dirty
  logic   req_is_write; // registered request is a store

  modport ctrl (
    output req_load, tag_write, data_write, refill_sel,
    output dirty_set, dirty_clear, victim_sel, flush_line,
    input  hit, victim_dirty, line_dirty, req_is_write
  );

  modport dpath (
    input  req_load, tag_write, data_write, refill_sel,
    input  dirty_set, dirty_clear, victim_sel, flush_line,
    output hit, victim_dirty, line_dirty, req_is_write
  );

endinterface

`default_nettype wire

// ==== cache_word_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_word_counter import cache_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    word_inc,    // one word moved to or from memory
  input  logic    word_clear,  // controller is idle in tag_check
  input  logic    line_inc,    // flush walk moves to next line
  output offset_t word_count,
  output index_t  line_count,
  output logic    word_last,   // last word of the line
  output logic    line_last    // last line of the cache
);

  offset_t word_q;
  index_t  line_q;

  // ============================================================
  // counters
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      word_q <= '0;
      line_q <= '0;
    end else begin
      if (word_clear) begin
        word_q <= '0;
      end else if (word_inc) begin
        word_q <= word_q + 1'b1;  // wraps to 0 after 15
      end
      // word_clear only comes while no flush walk is running
      if (word_clear) begin
        line_q <= '0;
      end else if (line_inc) begin
        line_q <= line_q + 1'b1;
      end
    end
  end

  assign word_count = word_q;
  assign line_count = line_q;
  assign word_last  = (word_q == offset_t'(`CACHE_WORDS_PER_LINE - 1));
  assign line_last  = (line_q == index_t'(`CACHE_LINES - 1));

  // idle clear and transfer count come from different controller states
  assert property (@(posedge clk) disable iff (reset) !(word_inc && word_clear))
    else $error("word counter told to clear and advance in one cycle");

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic flush,           // level request to write back dirty lines
  output logic flush_done,      // held until flush falls
  input  logic memreq_val,
  output logic memreq_rdy,
  output logic memresp_val,
  input  logic memresp_rdy,
  output logic cache_req_val,
  input  logic cache_req_rdy,
  output logic cache_req_write,
  input  logic cache_resp_val,
  output logic cache_resp_rdy,
  output logic word_inc,
  output logic word_clear,
  output logic line_inc,
  input  logic word_last,
  input  logic line_last,
  cache_dpath_if.ctrl dp
);

  ctrl_state_t state, state_next;

  logic       started;       // first cycle out of reset has passed
  logic       req_pending;   // request accepted but not answered
  logic       resp_pending;  // response waiting for the processor
  logic       wait_resp;     // refill read issued and awaiting data
  logic       flushing;      // flush walk in progress
  index_t     flush_idx;     // line being inspected by the walk
  logic       idle;
  logic       flush_start;
  logic       hit_done;      // pending request completes this cycle
  logic       walk_end;      // flush walk finished this cycle
  logic       req_xfer;
  logic       resp_xfer;
  logic [4:0] cs;

  assign idle        = (state == tag_check) && !req_pending && !resp_pending;
  assign memreq_rdy  = idle && !flush && started;  // flush wins over new work
  assign memresp_val = resp_pending;
  assign flush_start = idle && flush && !flush_done;
  assign hit_done    = (state == tag_check) && req_pending && dp.hit;
  assign req_xfer    = cache_req_val && cache_req_rdy;
  assign resp_xfer   = cache_resp_val && cache_resp_rdy;

  assign dp.req_load   = memreq_val && memreq_rdy;
  assign dp.victim_sel = flushing;
  assign dp.flush_line = flush_idx;

  // ============================================================
  // per-state control table
  // ============================================================

  always_comb begin
    case (state)
      //                 req_val      req_wr resp_rdy   refill wclr
      tag_check:  cs = {1'b0,        1'b0,  1'b0,      1'b0,  1'b1};
      evict:      cs = {1'b1,        1'b1,  1'b0,      1'b0,  1'b0};
      refill:     cs = {!wait_resp,  1'b0,  wait_resp, 1'b1,  1'b0};
      flush_scan: cs = {1'b0,        1'b0,  1'b0,      1'b0,  1'b0};
      default:    cs = '0;
    endcase
  end

  assign {cache_req_val, cache_req_write, cache_resp_rdy, dp.refill_sel, word_clear} = cs;

  // ============================================================
  // transitions and event strobes
  // ============================================================

  always_comb begin
    state_next     = state;
    dp.tag_write   = 1'b0;
    dp.data_write  = 1'b0;
    dp.dirty_set   = 1'b0;
    dp.dirty_clear = 1'b0;
    word_inc       = 1'b0;
    line_inc       = 1'b0;
    walk_end       = 1'b0;
    case (state)
      tag_check: begin
        if (req_pending) begin
          if (dp.hit) begin
            dp.data_write = dp.req_is_write;  // store lands in the array
            dp.dirty_set  = dp.req_is_write;
          end else if (dp.victim_dirty) begin
            state_next = evict;
          end else begin
            state_next = refill;
          end
        end else if (flush_start) begin
          state_next = flush_scan;
        end
      end
      evict: begin
        if (req_xfer) begin
          word_inc = 1'b1;
          if (word_last && !flushing) begin
            state_next = refill;                // victim gone, fetch new line
          end else if (word_last) begin
            dp.dirty_clear = 1'b1;
            if (line_last) begin
              walk_end   = 1'b1;
              state_next = tag_check;
            end else begin
              line_inc   = 1'b1;
              state_next = flush_scan;
            end
          end
        end
      end
      refill: begin
        if (resp_xfer) begin
          dp.data_write = 1'b1;
          word_inc      = 1'b1;
          if (word_last) begin
            dp.tag_write   = 1'b1;              // line complete
            dp.dirty_clear = 1'b1;
            state_next     = tag_check;         // request retries as a hit
          end
        end
      end
      flush_scan: begin
        if (dp.line_dirty) begin
          state_next = evict;
        end else if (line_last) begin
          walk_end   = 1'b1;
          state_next = tag_check;
        end else begin
          line_inc = 1'b1;                      // clean or invalid line skipped
        end
      end
      default: state_next = tag_check;
    endcase
  end

  // ============================================================
  // state and control registers
  // ============================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= tag_check;
      started      <= 1'b0;
      req_pending  <= 1'b0;
      resp_pending <= 1'b0;
      wait_resp    <= 1'b0;
      flushing     <= 1'b0;
      flush_done   <= 1'b0;
      flush_idx    <= '0;
    end else begin
      state   <= state_next;
      started <= 1'b1;
      if (dp.req_load) begin
        req_pending <= 1'b1;
      end else if (hit_done) begin
        req_pending <= 1'b0;
      end
      if (hit_done) begin
        resp_pending <= 1'b1;
      end else if (memresp_val && memresp_rdy) begin
        resp_pending <= 1'b0;
      end
      if (req_xfer && !cache_req_write) begin
        wait_resp <= 1'b1;                      // one read in flight
      end else if (resp_xfer) begin
        wait_resp <= 1'b0;
      end
      if (flush_start) begin
        flushing <= 1'b1;
      end else if (walk_end) begin
        flushing <= 1'b0;
      end
      if (walk_end) begin
        flush_done <= 1'b1;
      end else if (!flush) begin
        flush_done <= 1'b0;                     // rearm once flush drops
      end
      if (word_clear) begin
        flush_idx <= '0;                        // tracks the line counter
      end else if (line_inc) begin
        flush_idx <= flush_idx + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    cache_req_val && !cache_req_rdy |=> cache_req_val)
    else $error("memory request withdrawn before transfer");

  assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val)
    else $error("processor response dropped while stalled");

endmodule

`default_nettype wire

// ==== cache_dpath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_dpath import cache_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  cache_dpath_if.dpath dp,
  input  logic    memreq_write,
  input  addr_t   memreq_addr,
  input  word_t   memreq_data,
  output word_t   memresp_data,
  output addr_t   cache_req_addr,
  output word_t   cache_req_data,
  input  word_t   cache_resp_data,
  input  offset_t word_count,   // word position during evict and refill
  input  index_t  line_count    // line position during flush
);

  // ============================================================
  // storage
  // ============================================================

  tag_t                    tag_array  [`CACHE_LINES];
  word_t                   data_array [`CACHE_LINES * `CACHE_WORDS_PER_LINE];
  logic [`CACHE_LINES-1:0] valid_bits;
  logic [`CACHE_LINES-1:0] dirty_bits;

  logic    req_write_q;  // request registers
  addr_t   req_addr_q;
  word_t   req_data_q;
  word_t   resp_q;       // word returned to the processor

  tag_t    req_tag;
  index_t  req_idx;
  offset_t req_off;
  index_t  ev_idx;       // line being written back
  index_t  clr_idx;      // line whose dirty bit clears
  offset_t wr_off;
  word_t   wr_data;
  addr_t   evict_addr;
  addr_t   refill_addr;

  assign {req_tag, req_idx, req_off} = req_addr_q;

  // ============================================================
  // lookup and status
  // ============================================================

  assign dp.hit          = valid_bits[req_idx] && (tag_array[req_idx] == req_tag);
  assign dp.victim_dirty = valid_bits[req_idx] && dirty_bits[req_idx];
  assign dp.line_dirty   = valid_bits[dp.flush_line] && dirty_bits[dp.flush_line];
  assign dp.req_is_write = req_write_q;

  // address and data muxing
  assign ev_idx      = dp.victim_sel ? line_count : req_idx;      // flush walk or miss
  assign clr_idx     = dp.victim_sel ? dp.flush_line : req_idx;
  assign evict_addr  = {tag_array[ev_idx], ev_idx, word_count};   // victim's old address
  assign refill_addr = {req_tag, req_idx, word_count};
  assign wr_off      = dp.refill_sel ? word_count : req_off;
  assign wr_data     = dp.refill_sel ? cache_resp_data : req_data_q;

  assign cache_req_addr = dp.refill_sel ? refill_addr : evict_addr;
  assign cache_req_data = data_array[{ev_idx, word_count}];
  assign memresp_data   = resp_q;

  // ============================================================
  // arrays and payload registers
  // ============================================================

  always_ff @(posedge clk) begin
    if (dp.req_load) begin
      req_write_q <= memreq_write;
      req_addr_q  <= memreq_addr;
      req_data_q  <= memreq_data;
    end
    if (dp.data_write) begin
      data_array[{req_idx, wr_off}] <= wr_data;    // store or refill word
    end
    if (dp.tag_write) begin
      tag_array[req_idx] <= req_tag;
    end
    // array and request are frozen while a response waits
    if (dp.hit) begin
      resp_q <= req_write_q ? req_data_q : data_array[{req_idx, req_off}];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (dp.tag_write) begin
        valid_bits[req_idx] <= 1'b1;
      end
      if (dp.dirty_set) begin
        dirty_bits[req_idx] <= 1'b1;
      end
      if (dp.dirty_clear) begin
        dirty_bits[clr_idx] <= 1'b0;
      end
    end
  end

  // a store hit never overlaps refill data entry
  assert property (@(posedge clk) disable iff (reset)
    (dp.data_write && dp.hit && dp.req_is_write) |-> !dp.refill_sel)
    else $error("refill write collided with store completion");

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  // processor side
  input  logic  memreq_val,
  output logic  memreq_rdy,
  input  logic  memreq_write,
  input  addr_t memreq_addr,
  input  word_t memreq_data,
  output logic  memresp_val,
  input  logic  memresp_rdy,
  output word_t memresp_data,
  // memory side
  output logic  cache_req_val,
  input  logic  cache_req_rdy,
  output logic  cache_req_write,
  output addr_t cache_req_addr,
  output word_t cache_req_data,
  input  logic  cache_resp_val,
  output logic  cache_resp_rdy,
  input  word_t cache_resp_data,
  // flush
  input  logic  flush,
  output logic  flush_done
);

  logic    word_inc;
  logic    word_clear;
  logic    line_inc;
  logic    word_last;
  logic    line_last;
  offset_t word_count;
  index_t  line_count;

  cache_dpath_if dp_if ();

  cache_ctrl ctrl_inst (
    .clk, .reset, .flush, .flush_done,
    .memreq_val, .memreq_rdy, .memresp_val, .memresp_rdy,
    .cache_req_val, .cache_req_rdy, .cache_req_write,
    .cache_resp_val, .cache_resp_rdy,
    .word_inc, .word_clear, .line_inc, .word_last, .line_last,
    .dp (dp_if.ctrl)
  );

  cache_word_counter counter_inst (
    .clk, .reset, .word_inc, .word_clear, .line_inc,
    .word_count, .line_count, .word_last, .line_last
  );

  cache_dpath dpath_inst (
    .clk, .reset, .dp (dp_if.dpath),
    .memreq_write, .memreq_addr, .memreq_data, .memresp_data,
    .cache_req_addr, .cache_req_data, .cache_resp_data,
    .word_count, .line_count
  );

endmodule

`default_nettype wire

// ==== tb_cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_cache_checker import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  memreq_val,
  input  logic  memreq_rdy,
  input  logic  memreq_write,
  input  addr_t memreq_addr,
  input  word_t memreq_data,
  input  logic  memresp_val,
  input  logic  memresp_rdy,
  input  word_t memresp_data,
  input  logic  cache_req_val,
  input  logic  cache_req_rdy,
  input  logic  cache_req_write,
  input  addr_t cache_req_addr,
  input  word_t cache_req_data,
  input  logic  cache_resp_rdy,
  input  logic  flush_done,
  input  logic  row_end,      // closes the current table row
  input  int    row_num,
  input  int    exp_rd,       // memory reads the row should cause
  input  int    exp_wr,       // memory writes the row should cause
  input  int    exp_resp,     // processor responses the row should see
  output int    pass_count,
  output int    fail_count
);

  localparam int MEM_WORDS = 1 << `CACHE_ADDR_W;

  word_t shadow [MEM_WORDS];  // what the processor should read back
  word_t image  [MEM_WORDS];  // backing memory as seen on the bus
  addr_t req_addr;            // last accepted processor request
  logic  req_wr;
  logic  row_bad;
  logic  held;                // response stalled on the last edge
  logic  done_q;
  word_t held_data;
  int    n_rd;
  int    n_wr;
  int    n_resp;
  int    reset_cycles;

  task automatic report_fail(input string msg);
    $display("Fail at time %0t: row %0d %s", $time, row_num, msg);
    row_bad = 1'b1;
  endtask

  initial begin
    for (int a = 0; a < MEM_WORDS; a++) begin
      shadow[a] = word_t'(a) ^ 32'h5a5a0000;  // same power-up pattern as memory
      image[a]  = word_t'(a) ^ 32'h5a5a0000;
    end
    {req_wr, row_bad, held, done_q} = '0;
    req_addr     = '0;
    held_data    = '0;
    n_rd         = 0;
    n_wr         = 0;
    n_resp       = 0;
    reset_cycles = 0;
    pass_count   = 0;
    fail_count   = 0;
  end

  // ============================================================
  // bus monitor, sampled on the rising edge
  // ============================================================

  always @(posedge clk) begin : watch
    addr_t exp_addr;
    int    bad;
    if (reset) begin
      reset_cycles++;
      if (reset_cycles > 1 && (memresp_val || cache_req_val || flush_done ||
                               memreq_rdy || cache_resp_rdy)) begin
        $display("Fail at time %0t: outputs not idle during reset", $time);
        fail_count++;
      end
    end else begin
      if (memreq_val && memreq_rdy) begin
        req_addr = memreq_addr;
        req_wr   = memreq_write;
        if (memreq_write) shadow[memreq_addr] = memreq_data;  // store seen at accept
      end
      if (cache_req_val && cache_req_rdy) begin
        if (cache_req_write) begin
          n_wr++;
          if (cache_req_data !== shadow[cache_req_addr])
            report_fail($sformatf("write-back to %03h has %08h, expected %08h",
                                  cache_req_addr, cache_req_data, shadow[cache_req_addr]));
          image[cache_req_addr] = cache_req_data;
        end else begin
          exp_addr = {req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], offset_t'(n_rd)};
          if (cache_req_addr !== exp_addr)
            report_fail($sformatf("refill read at %03h, expected %03h",
                                  cache_req_addr, exp_addr));
          n_rd++;
        end
      end
      if (memresp_val) begin
        if (held && memresp_data !== held_data)
          report_fail("response data changed while stalled");
        held      = !memresp_rdy;
        held_data = memresp_data;
        if (memresp_rdy) begin
          n_resp++;
          if (!req_wr && memresp_data !== shadow[req_addr])
            report_fail($sformatf("load %03h returned %08h, expected %08h",
                                  req_addr, memresp_data, shadow[req_addr]));
        end
      end else begin
        held = 1'b0;
      end
      // after a flush nothing dirty is left, memory must match everywhere
      if (flush_done && !done_q) begin
        bad = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
          if (image[a] !== shadow[a]) begin
            if (bad == 0)
              report_fail($sformatf("memory %03h holds %08h after flush, expected %08h",
                                    a, image[a], shadow[a]));
            bad++;
          end
        end
      end
      done_q = flush_done;
      if (row_end) begin
        if (n_rd != exp_rd) report_fail($sformatf("%0d memory reads, expected %0d", n_rd, exp_rd));
        if (n_wr != exp_wr) report_fail($sformatf("%0d memory writes, expected %0d", n_wr, exp_wr));
        if (n_resp != exp_resp) report_fail($sformatf("%0d responses, expected %0d", n_resp, exp_resp));
        if (row_bad) begin
          fail_count++;
          $display("row %0d failed", row_num);
        end else begin
          pass_count++;
          $display("row %0d ok: %0d reads, %0d writes", row_num, n_rd, n_wr);
        end
        n_rd    = 0;
        n_wr    = 0;
        n_resp  = 0;
        row_bad = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_cache import cache_pkg::*; ();

  localparam int ROWS      = 19;
  localparam int TIMEOUT   = 2000;              // cycles per wait
  localparam int MEM_WORDS = 1 << `CACHE_ADDR_W;
  localparam int OP_READ   = 0;
  localparam int OP_WRITE  = 1;
  localparam int OP_FLUSH  = 2;

  logic  clk = 1'b0;
  logic  reset;
  logic  flush, flush_done;
  logic  memreq_val, memreq_rdy, memreq_write;
  addr_t memreq_addr;
  word_t memreq_data;
  logic  memresp_val, memresp_rdy;
  word_t memresp_data;
  logic  cache_req_val, cache_req_rdy, cache_req_write;
  addr_t cache_req_addr;
  word_t cache_req_data;
  logic  cache_resp_val, cache_resp_rdy;
  word_t cache_resp_data;

  logic  row_end;
  int    row_num, exp_rd, exp_wr, exp_resp;
  int    pass_count, fail_count, timeouts;

  // stimulus table: operation, address, store data, expected memory reads and writes
  int    op_tbl   [ROWS];
  addr_t addr_tbl [ROWS];
  word_t data_tbl [ROWS];
  int    rd_tbl   [ROWS];
  int    wr_tbl   [ROWS];
  int    row_count;

  // backing memory
  word_t mem [MEM_WORDS];
  logic  rd_pending;   // read accepted, data not yet presented
  logic  resp_taken;   // response transferred on the last edge
  logic  seeded;
  addr_t rd_addr;

  cache_top cache_top_inst (.*);

  tb_cache_checker check_inst (.*);

  initial forever #10 clk = ~clk;  // 20 ns period

  // ============================================================
  // memory responder
  // ============================================================

  always @(posedge clk) begin
    if (cache_req_val && cache_req_rdy) begin
      if (cache_req_write) begin
        mem[cache_req_addr] = cache_req_data;   // write lands as it transfers
      end else begin
        rd_pending = 1'b1;
        rd_addr    = cache_req_addr;
      end
    end
    if (cache_resp_val && cache_resp_rdy) resp_taken = 1'b1;
  end

  always @(negedge clk) begin
    if (!seeded) begin
      void'($urandom(32'hf5c4));
      seeded = 1'b1;
    end
    if (resp_taken) begin
      cache_resp_val = 1'b0;
      resp_taken     = 1'b0;
    end
    if (rd_pending && ($urandom % 2 == 0)) begin  // random extra read latency
      cache_resp_val  = 1'b1;
      cache_resp_data = mem[rd_addr];
      rd_pending      = 1'b0;
    end
    if (!reset) begin
      cache_req_rdy = ($urandom % 4) != 0;        // memory stalls now and then
      memresp_rdy   = ($urandom % 3) != 0;        // processor back-pressure
    end
  end

  // ============================================================
  // stimulus
  // ============================================================

  task automatic add_row(input int op, input addr_t addr, input word_t data,
                         input int n_rd, input int n_wr);
    op_tbl[row_count]   = op;
    addr_tbl[row_count] = addr;
    data_tbl[row_count] = data;
    rd_tbl[row_count]   = n_rd;
    wr_tbl[row_count]   = n_wr;
    row_count++;
  endtask

  task automatic run_access(input logic wr, input addr_t addr, input word_t data,
                            output logic ok);
    int   n;
    logic got;
    @(negedge clk);
    memreq_val   = 1'b1;
    memreq_write = wr;
    memreq_addr  = addr;
    memreq_data  = data;
    got = 1'b0;
    for (n = 0; n < TIMEOUT && !got; n++) begin
      @(posedge clk);
      got = memreq_rdy;
    end
    @(negedge clk);
    memreq_val = 1'b0;
    if (got) begin
      got = 1'b0;
      for (n = 0; n < TIMEOUT && !got; n++) begin
        @(posedge clk);
        got = memresp_val && memresp_rdy;
      end
      if (!got) $display("timeout: row %0d never got its response", row_num);
    end else begin
      $display("timeout: row %0d request was never accepted", row_num);
    end
    if (!got) timeouts++;
    ok = got;
  endtask

  task automatic run_flush(output logic ok);
    int   n;
    logic got;
    @(negedge clk);
    flush = 1'b1;
    got   = 1'b0;
    for (n = 0; n < TIMEOUT && !got; n++) begin
      @(posedge clk);
      got = flush_done;
    end
    @(negedge clk);
    flush = 1'b0;
    if (got) begin
      got = 1'b0;
      for (n = 0; n < TIMEOUT && !got; n++) begin
        @(posedge clk);
        got = !flush_done;                          // done drops once flush falls
      end
      if (!got) $display("timeout: row %0d flush_done stayed high after flush fell", row_num);
    end else begin
      $display("timeout: row %0d flush never finished", row_num);
    end
    if (!got) timeouts++;
    ok = got;
  endtask

  task automatic end_row();
    @(negedge clk);
    row_end = 1'b1;
    @(negedge clk);
    row_end = 1'b0;
  endtask

  initial begin
    int   i;
    logic ok;
    reset = 1'b1;
    flush = 1'b0;
    {memreq_val, memreq_write} = '0;
    memreq_addr = '0;
    memreq_data = '0;
    memresp_rdy = 1'b1;
    cache_req_rdy = 1'b1;
    cache_resp_val = 1'b0;
    cache_resp_data = '0;
    {row_end, rd_pending, resp_taken, seeded} = '0;
    rd_addr = '0;
    row_num = 0;
    exp_rd = 0;
    exp_wr = 0;
    exp_resp = 0;
    timeouts = 0;
    row_count = 0;
    for (i = 0; i < MEM_WORDS; i++) mem[i] = word_t'(i) ^ 32'h5a5a0000;
    add_row(OP_READ,  12'h013, 32'h0,         16, 0);   // cold miss
    add_row(OP_WRITE, 12'h013, 32'hdead0001,   0, 0);   // store hit
    add_row(OP_READ,  12'h013, 32'h0,          0, 0);   // load hit
    add_row(OP_WRITE, 12'h025, 32'hdead0002,  16, 0);   // write allocate
    add_row(OP_READ,  12'h125, 32'h0,         16, 16);  // dirty conflict on line 2
    add_row(OP_READ,  12'h025, 32'h0,         16, 0);   // back from memory
    add_row(OP_WRITE, 12'h03a, 32'hdead0003,  16, 0);
    add_row(OP_WRITE, 12'h03b, 32'hdead0004,   0, 0);
    add_row(OP_WRITE, 12'h210, 32'hdead0005,  16, 16);  // dirty conflict on line 1
    add_row(OP_FLUSH, 12'h000, 32'h0,          0, 32);  // lines 1 and 3 dirty
    add_row(OP_FLUSH, 12'h000, 32'h0,          0, 0);   // nothing left dirty
    add_row(OP_READ,  12'h03a, 32'h0,          0, 0);   // lines stay valid
    add_row(OP_READ,  12'h013, 32'h0,         16, 0);
    add_row(OP_WRITE, 12'h7f0, 32'hcafe0007,  16, 0);
    add_row(OP_READ,  12'h7f0, 32'h0,          0, 0);
    add_row(OP_WRITE, 12'h4f1, 32'hcafe0008,  16, 16);
    add_row(OP_READ,  12'h7f0, 32'h0,         16, 16);
    add_row(OP_WRITE, 12'h7f5, 32'hcafe0009,   0, 0);
    add_row(OP_FLUSH, 12'h000, 32'h0,          0, 16);  // only line 7 dirty
    repeat (16) @(negedge clk);
    reset = 1'b0;
    ok = 1'b0;
    for (i = 0; i < 20 && !ok; i++) begin
      @(posedge clk);
      ok = memreq_rdy;
    end
    if (!ok) begin
      $display("timeout: memreq_rdy never came up after reset");
      timeouts++;
    end
    for (i = 0; i < ROWS && ok; i++) begin
      row_num  = i;
      exp_rd   = rd_tbl[i];
      exp_wr   = wr_tbl[i];
      exp_resp = (op_tbl[i] == OP_FLUSH) ? 0 : 1;
      if (op_tbl[i] == OP_FLUSH) run_flush(ok);
      else run_access(op_tbl[i] == OP_WRITE, addr_tbl[i], data_tbl[i], ok);
      if (ok) end_row();
    end
    @(negedge clk);
    $display("rows passed %0d, failed %0d, timeouts %0d", pass_count, fail_count, timeouts);
    if (fail_count == 0 && timeouts == 0 && pass_count == ROWS) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_subsys.f ====
+incdir+.
cache_pkg.sv
cache_dpath_if.sv
cache_word_counter.sv
cache_ctrl.sv
cache_dpath.sv
cache_top.sv
tb_cache_checker.sv
tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cache_subsys.f --top-module tb_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
